// File: build.f
+incdir+include
design/vdec_pkg.sv
design/vdec_operand_if.sv
design/vdec_mem_dec.sv
design/vdec_vsetvl_dec.sv
design/vdec_arith_dec.sv
design/vdec_csr_dec.sv
design/vdec_ctrl.sv
design/vdec_top.sv
dv/vdec_properties.sv
dv/vdec_tb.sv

// File: design/vdec_arith_dec.sv
// OPI integer arithmetic decoder, VV, VX and VI forms
`timescale 1ns/100ps

module vdec_arith_dec (
  vdec_operand_if.dec        op_if,
  output vdec_pkg::vec_req_t req_o,
  output logic               illegal_o
);
  import vdec_pkg::*;

  logic [5:0] funct6;
  logic [2:0] funct3;
  vreg_t      s1_field;

  assign funct6   = op_if.instr[31:26];
  assign funct3   = op_if.instr[14:12];
  assign s1_field = op_if.instr[19:15];

  always_comb begin
    req_o         = '0;
    illegal_o     = 1'b0;
    req_o.ex_unit = VFU;
    req_o.vs2     = op_if.instr[24:20];
    req_o.use_vs2 = 1'b1;
    req_o.vd      = op_if.instr[11:7];
    req_o.use_vd  = 1'b1;
    req_o.vm      = op_if.instr[25];

    // Operand form
    case (funct3)
      OPIVV: begin
        req_o.vs1     = s1_field;
        req_o.use_vs1 = 1'b1;
      end
      OPIVI: req_o.rs1 = xlen_t'(signed'(s1_field));
      OPIVX: begin
        req_o.rs1 = op_if.rs1;
        illegal_o = ~op_if.rs1_valid;
      end
      default: illegal_o = 1'b1;
    endcase

    case (funct6)
      F6_VADD: req_o.op = VADD;
      F6_VSUB: begin
        req_o.op = VSUB;
        if (funct3 == OPIVI) illegal_o = 1'b1;
      end
      F6_VRSUB: begin
        req_o.op = VRSUB;
        if (funct3 == OPIVV) illegal_o = 1'b1;
      end
      F6_VAND: req_o.op = VAND;
      F6_VOR:  req_o.op = VOR;
      F6_VXOR: req_o.op = VXOR;
      F6_VSLL: req_o.op = VSLL;
      F6_VSRL: req_o.op = VSRL;
      F6_VSRA: req_o.op = VSRA;
      default: illegal_o = 1'b1;
    endcase
  end

endmodule

// File: design/vdec_csr_dec.sv
// Vector CSR access decoder with vstart write, set and clear flags
`timescale 1ns/100ps

module vdec_csr_dec (
  vdec_operand_if.dec        op_if,
  output vdec_pkg::vec_req_t req_o,
  output logic               illegal_o
);
  import vdec_pkg::*;

  csr_addr_t  csr_addr;
  vreg_t      rd_field;
  vreg_t      rs1_field;
  logic [2:0] funct3;
  logic       addr_ok;
  logic       is_vstart;

  assign csr_addr  = op_if.instr[31:20];
  assign rd_field  = op_if.instr[11:7];
  assign rs1_field = op_if.instr[19:15];
  assign funct3    = op_if.instr[14:12];
  assign addr_ok   = csr_addr inside {CSR_VSTART, CSR_VXSAT, CSR_VXRM, CSR_VCSR,
                                      CSR_VL, CSR_VTYPE, CSR_VLENB};
  assign is_vstart = (csr_addr == CSR_VSTART);

  always_comb begin
    req_o          = '0;
    req_o.op       = VCSR;
    req_o.ex_unit  = CON;
    req_o.rd       = rd_field;
    req_o.use_rd   = 1'b1;
    req_o.csr_addr = csr_addr;

    // Immediate forms carry the zero-extended rs1 field
    if (funct3[2]) begin
      req_o.rs1 = xlen_t'(rs1_field);
      illegal_o = 1'b0;
    end else begin
      req_o.rs1 = op_if.rs1;
      illegal_o = ~op_if.rs1_valid;
    end

    if (!addr_ok) illegal_o = 1'b1;

    case (funct3[1:0])
      2'b01: begin
        if (is_vstart) begin
          req_o.use_rd       = (rd_field != '0);
          req_o.write_vstart = 1'b1;
        end
      end
      2'b10: req_o.set_vstart   = is_vstart && (rs1_field != '0);
      2'b11: req_o.clear_vstart = is_vstart && (rs1_field != '0);
      default: illegal_o = 1'b1;
    endcase
  end

endmodule

// File: design/vdec_ctrl.sv
// Instruction classification, decoder result select and response register
`timescale 1ns/100ps

module vdec_ctrl (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                req_valid_i,
  input  vdec_pkg::trans_id_t id_i,
  input  logic [6:0]          opcode_i,
  input  logic [2:0]          funct3_i,
  input  vdec_pkg::vec_req_t  mem_req_i,
  input  logic                mem_illegal_i,
  input  vdec_pkg::vec_req_t  cfg_req_i,
  input  logic                cfg_illegal_i,
  input  vdec_pkg::vec_req_t  arith_req_i,
  input  logic                arith_illegal_i,
  input  vdec_pkg::vec_req_t  csr_req_i,
  input  logic                csr_illegal_i,
  output logic                rsp_valid_o,
  output logic                illegal_o,
  output logic                reset_vstart_o,
  output vdec_pkg::trans_id_t id_o,
  output vdec_pkg::vec_req_t  req_o
);
  import vdec_pkg::*;

  instr_class_e cls;
  vec_req_t     sel_req;
  logic         sel_illegal;
  logic         sel_reset_vstart;

  logic         rsp_valid_q;
  logic         illegal_q;
  logic         reset_vstart_q;
  logic [3:0]   use_q;
  logic [2:0]   vstart_q;
  vec_req_t     req_q;
  trans_id_t    id_q;

  always_comb begin
    case (opcode_i)
      OPC_LOAD_FP, OPC_STORE_FP: cls = CLS_MEM;
      OPC_VEC:                   cls = (funct3_i == OPCFG) ? CLS_CFG : CLS_ARITH;
      OPC_SYSTEM:                cls = CLS_CSR;
      default:                   cls = CLS_NONE;
    endcase
  end

  // Result of the selected class decoder
  always_comb begin
    sel_req     = '0;
    sel_illegal = 1'b1;
    case (cls)
      CLS_MEM: begin
        sel_req     = mem_req_i;
        sel_illegal = mem_illegal_i;
      end
      CLS_CFG: begin
        sel_req     = cfg_req_i;
        sel_illegal = cfg_illegal_i;
      end
      CLS_ARITH: begin
        sel_req     = arith_req_i;
        sel_illegal = arith_illegal_i;
      end
      CLS_CSR: begin
        sel_req     = csr_req_i;
        sel_illegal = csr_illegal_i;
      end
      default: sel_illegal = 1'b1;
    endcase
    sel_reset_vstart = (cls != CLS_CSR) & ~sel_illegal;
  end

  ////////////////////////////////////////
  // Response register
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q    <= 1'b0;
      illegal_q      <= 1'b0;
      reset_vstart_q <= 1'b0;
      use_q          <= '0;
      vstart_q       <= '0;
    end else begin
      rsp_valid_q    <= req_valid_i;
      illegal_q      <= req_valid_i & sel_illegal;
      reset_vstart_q <= req_valid_i & sel_reset_vstart;
      // Illegal requests claim no operands and touch no vstart
      if (req_valid_i && !sel_illegal) begin
        use_q    <= {sel_req.use_vd, sel_req.use_vs1, sel_req.use_vs2, sel_req.use_rd};
        vstart_q <= {sel_req.write_vstart, sel_req.set_vstart, sel_req.clear_vstart};
      end else begin
        use_q    <= '0;
        vstart_q <= '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      req_q <= sel_req;
      id_q  <= id_i;
    end
  end

  always_comb begin
    req_o = req_q;
    {req_o.use_vd, req_o.use_vs1, req_o.use_vs2, req_o.use_rd} = use_q;
    {req_o.write_vstart, req_o.set_vstart, req_o.clear_vstart} = vstart_q;
  end

  assign rsp_valid_o    = rsp_valid_q;
  assign illegal_o      = illegal_q;
  assign reset_vstart_o = reset_vstart_q;
  assign id_o           = id_q;

endmodule

// File: design/vdec_mem_dec.sv
// Vector load and store decoder, unit-stride and strided
`timescale 1ns/100ps

module vdec_mem_dec (
  vdec_operand_if.dec        op_if,
  output vdec_pkg::vec_req_t req_o,
  output logic               illegal_o
);
  import vdec_pkg::*;

  logic [2:0] nf;
  logic       mew;
  logic [1:0] mop;
  logic [4:0] lumop;
  logic [2:0] width;
  logic       is_load;

  assign nf      = op_if.instr[31:29];
  assign mew     = op_if.instr[28];
  assign mop     = op_if.instr[27:26];
  assign lumop   = op_if.instr[24:20];
  assign width   = op_if.instr[14:12];
  // LOAD-FP and STORE-FP differ in bit 5
  assign is_load = ~op_if.instr[5];

  always_comb begin
    req_o           = '0;
    illegal_o       = 1'b0;
    req_o.ex_unit   = LSU;
    req_o.vd        = op_if.instr[11:7];
    req_o.use_vd    = 1'b1;
    req_o.vd_is_src = ~is_load;
    req_o.is_load   = is_load;
    req_o.vm        = op_if.instr[25];
    req_o.rs1       = op_if.rs1;

    case ({mew, width})
      4'b0000: req_o.vsew = EW_8;
      4'b0101: req_o.vsew = EW_16;
      4'b0110: req_o.vsew = EW_32;
      default: illegal_o = 1'b1;
    endcase

    case (mop)
      2'b00: begin
        req_o.op = is_load ? VLE : VSE;
        if (lumop != '0) illegal_o = 1'b1;
      end
      2'b10: begin
        req_o.op  = is_load ? VLSE : VSSE;
        req_o.rs2 = op_if.rs2;
        if (!op_if.rs2_valid) illegal_o = 1'b1;
      end
      default: illegal_o = 1'b1;
    endcase

    // No segment accesses
    if (nf != 3'b000 || !op_if.rs1_valid) illegal_o = 1'b1;
  end

endmodule

// File: design/vdec_operand_if.sv
// Instruction word and scalar operand bundle for the class decoders
`timescale 1ns/100ps

interface vdec_operand_if;
  import vdec_pkg::*;

  logic [31:0] instr;
  xlen_t       rs1;
  logic        rs1_valid;
  xlen_t       rs2;
  logic        rs2_valid;

  // Driven from the top level ports
  modport src (output instr, rs1, rs1_valid, rs2, rs2_valid);

  modport dec (input instr, rs1, rs1_valid, rs2, rs2_valid);

endinterface

// File: design/vdec_pkg.sv
// Decoder typedefs, enums, request struct, opcode, funct and CSR constants
`include "vdec_cfg.svh"

package vdec_pkg;

  typedef logic [`VDEC_XLEN-1:0]    xlen_t;
  typedef logic [`VDEC_ID_W-1:0]    trans_id_t;
  typedef logic [`VDEC_VREG_W-1:0]  vreg_t;
  typedef logic [`VDEC_VTYPE_W-1:0] vtype_t;
  typedef logic [`VDEC_CSR_W-1:0]   csr_addr_t;

  typedef enum logic [1:0] {EW_8, EW_16, EW_32} vsew_e;

  typedef enum logic [1:0] {CON, VFU, LSU} ex_unit_e;

  typedef enum logic [4:0] {
    VLE, VLSE, VSE, VSSE,
    VCFG, VCSR,
    VADD, VSUB, VRSUB,
    VAND, VOR, VXOR,
    VSLL, VSRL, VSRA
  } vec_op_e;

  typedef enum logic [2:0] {CLS_MEM, CLS_CFG, CLS_ARITH, CLS_CSR, CLS_NONE} instr_class_e;

  typedef struct packed {
    vec_op_e   op;
    ex_unit_e  ex_unit;
    vreg_t     vd;
    vreg_t     vs1;
    vreg_t     vs2;
    vreg_t     rd;
    logic      use_vd;
    logic      use_vs1;
    logic      use_vs2;
    logic      use_rd;
    logic      vd_is_src;
    xlen_t     rs1;
    xlen_t     rs2;
    vsew_e     vsew;
    logic      vm;
    logic      is_load;
    vtype_t    vtype;
    logic      keep_vl;
    csr_addr_t csr_addr;
    logic      write_vstart;
    logic      set_vstart;
    logic      clear_vstart;
  } vec_req_t;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
  localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
  localparam logic [6:0] OPC_VEC      = 7'b1010111;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

  // OP-V funct3
  localparam logic [2:0] OPIVV = 3'b000;
  localparam logic [2:0] OPIVI = 3'b011;
  localparam logic [2:0] OPIVX = 3'b100;
  localparam logic [2:0] OPCFG = 3'b111;

  localparam logic [5:0] F6_VADD  = 6'b000000;
  localparam logic [5:0] F6_VSUB  = 6'b000010;
  localparam logic [5:0] F6_VRSUB = 6'b000011;
  localparam logic [5:0] F6_VAND  = 6'b001001;
  localparam logic [5:0] F6_VOR   = 6'b001010;
  localparam logic [5:0] F6_VXOR  = 6'b001011;
  localparam logic [5:0] F6_VSLL  = 6'b100101;
  localparam logic [5:0] F6_VSRL  = 6'b101000;
  localparam logic [5:0] F6_VSRA  = 6'b101001;

  // Vector CSRs
  localparam csr_addr_t CSR_VSTART = 12'h008;
  localparam csr_addr_t CSR_VXSAT  = 12'h009;
  localparam csr_addr_t CSR_VXRM   = 12'h00A;
  localparam csr_addr_t CSR_VCSR   = 12'h00F;
  localparam csr_addr_t CSR_VL     = 12'hC20;
  localparam csr_addr_t CSR_VTYPE  = 12'hC21;
  localparam csr_addr_t CSR_VLENB  = 12'hC22;

endpackage

// File: design/vdec_top.sv
// Vector decoder top level with plain ports, operand interface and decoder instances
`timescale 1ns/100ps
`include "vdec_cfg.svh"

module vdec_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     req_valid_i,
  input  logic [31:0]              instr_i,
  input  logic [`VDEC_XLEN-1:0]    rs1_i,
  input  logic                     rs1_valid_i,
  input  logic [`VDEC_XLEN-1:0]    rs2_i,
  input  logic                     rs2_valid_i,
  input  logic [`VDEC_ID_W-1:0]    id_i,
  output logic                     rsp_valid_o,
  output logic                     illegal_o,
  output logic [`VDEC_ID_W-1:0]    id_o,
  output logic [4:0]               op_o,
  output logic [1:0]               ex_unit_o,
  output logic [`VDEC_VREG_W-1:0]  vd_o,
  output logic [`VDEC_VREG_W-1:0]  vs1_o,
  output logic [`VDEC_VREG_W-1:0]  vs2_o,
  output logic [`VDEC_VREG_W-1:0]  rd_o,
  output logic                     use_vd_o,
  output logic                     use_vs1_o,
  output logic                     use_vs2_o,
  output logic                     use_rd_o,
  output logic                     vd_is_src_o,
  output logic [`VDEC_XLEN-1:0]    rs1_o,
  output logic [`VDEC_XLEN-1:0]    rs2_o,
  output logic [1:0]               vsew_o,
  output logic                     vm_o,
  output logic                     is_load_o,
  output logic [`VDEC_VTYPE_W-1:0] vtype_o,
  output logic                     keep_vl_o,
  output logic [`VDEC_CSR_W-1:0]   csr_addr_o,
  output logic                     write_vstart_o,
  output logic                     set_vstart_o,
  output logic                     clear_vstart_o,
  output logic                     reset_vstart_o
);
  import vdec_pkg::*;

  vec_req_t mem_req;
  vec_req_t cfg_req;
  vec_req_t arith_req;
  vec_req_t csr_req;
  vec_req_t req;
  logic     mem_illegal;
  logic     cfg_illegal;
  logic     arith_illegal;
  logic     csr_illegal;

  vdec_operand_if op_if ();

  assign op_if.instr     = instr_i;
  assign op_if.rs1       = rs1_i;
  assign op_if.rs1_valid = rs1_valid_i;
  assign op_if.rs2       = rs2_i;
  assign op_if.rs2_valid = rs2_valid_i;

  ////////////////////////////////////////
  // Class decoders
  ////////////////////////////////////////

  vdec_mem_dec u_mem_dec (
    .op_if     (op_if),
    .req_o     (mem_req),
    .illegal_o (mem_illegal)
  );

  vdec_vsetvl_dec u_vsetvl_dec (
    .op_if     (op_if),
    .req_o     (cfg_req),
    .illegal_o (cfg_illegal)
  );

  vdec_arith_dec u_arith_dec (
    .op_if     (op_if),
    .req_o     (arith_req),
    .illegal_o (arith_illegal)
  );

  vdec_csr_dec u_csr_dec (
    .op_if     (op_if),
    .req_o     (csr_req),
    .illegal_o (csr_illegal)
  );

  vdec_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .req_valid_i     (req_valid_i),
    .id_i            (id_i),
    .opcode_i        (instr_i[6:0]),
    .funct3_i        (instr_i[14:12]),
    .mem_req_i       (mem_req),
    .mem_illegal_i   (mem_illegal),
    .cfg_req_i       (cfg_req),
    .cfg_illegal_i   (cfg_illegal),
    .arith_req_i     (arith_req),
    .arith_illegal_i (arith_illegal),
    .csr_req_i       (csr_req),
    .csr_illegal_i   (csr_illegal),
    .rsp_valid_o     (rsp_valid_o),
    .illegal_o       (illegal_o),
    .reset_vstart_o  (reset_vstart_o),
    .id_o            (id_o),
    .req_o           (req)
  );

  // Registered request out to plain ports
  assign op_o           = req.op;
  assign ex_unit_o      = req.ex_unit;
  assign vd_o           = req.vd;
  assign vs1_o          = req.vs1;
  assign vs2_o          = req.vs2;
  assign rd_o           = req.rd;
  assign use_vd_o       = req.use_vd;
  assign use_vs1_o      = req.use_vs1;
  assign use_vs2_o      = req.use_vs2;
  assign use_rd_o       = req.use_rd;
  assign vd_is_src_o    = req.vd_is_src;
  assign rs1_o          = req.rs1;
  assign rs2_o          = req.rs2;
  assign vsew_o         = req.vsew;
  assign vm_o           = req.vm;
  assign is_load_o      = req.is_load;
  assign vtype_o        = req.vtype;
  assign keep_vl_o      = req.keep_vl;
  assign csr_addr_o     = req.csr_addr;
  assign write_vstart_o = req.write_vstart;
  assign set_vstart_o   = req.set_vstart;
  assign clear_vstart_o = req.clear_vstart;

endmodule

// File: design/vdec_vsetvl_dec.sv
// Decoder for vsetvli, vsetivli and vsetvl
`timescale 1ns/100ps

module vdec_vsetvl_dec (
  vdec_operand_if.dec        op_if,
  output vdec_pkg::vec_req_t req_o,
  output logic               illegal_o
);
  import vdec_pkg::*;

  vreg_t rs1_field;
  vreg_t rd_field;

  assign rs1_field = op_if.instr[19:15];
  assign rd_field  = op_if.instr[11:7];

  always_comb begin
    req_o         = '0;
    illegal_o     = 1'b0;
    req_o.op      = VCFG;
    req_o.ex_unit = CON;
    req_o.rd      = rd_field;
    req_o.use_rd  = 1'b1;

    if (!op_if.instr[31]) begin
      req_o.vtype = vtype_t'(op_if.instr[27:20]);
      req_o.rs1   = op_if.rs1;
      illegal_o   = ~op_if.rs1_valid;
    end else if (op_if.instr[31:30] == 2'b11) begin
      // Immediate AVL
      req_o.vtype = vtype_t'(op_if.instr[27:20]);
      req_o.rs1   = xlen_t'(rs1_field);
    end else if (op_if.instr[31:25] == 7'b1000000) begin
      req_o.vtype = vtype_t'(op_if.rs2[7:0]);
      req_o.rs1   = op_if.rs1;
      illegal_o   = ~op_if.rs1_valid | ~op_if.rs2_valid;
    end else begin
      illegal_o = 1'b1;
    end

    // Request max vl
    if (rs1_field == '0 && rd_field != '0) req_o.rs1 = '1;
    req_o.keep_vl = (rs1_field == '0) && (rd_field == '0);
  end

endmodule

// File: dv/vdec_properties.sv
// Concurrent assertions on the decoder response, bound into the top level
`timescale 1ns/100ps

module vdec_properties (
  input logic clk_i,
  input logic rst_n_i,
  input logic req_valid_i,
  input logic rsp_valid_o,
  input logic illegal_o,
  input logic reset_vstart_o,
  input logic write_vstart_o,
  input logic set_vstart_o,
  input logic clear_vstart_o
);

  // One cycle from request to response
  a_rsp_timing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o == $past(req_valid_i))
    else $error("rsp_valid_o does not follow req_valid_i by one cycle");

  a_illegal_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    illegal_o |-> rsp_valid_o)
    else $error("illegal_o high without rsp_valid_o");

  a_illegal_no_reset: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(illegal_o && reset_vstart_o))
    else $error("illegal_o and reset_vstart_o high together");

  a_vstart_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({write_vstart_o, set_vstart_o, clear_vstart_o}))
    else $error("more than one vstart flag high");

endmodule

bind vdec_top vdec_properties u_props (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .req_valid_i    (req_valid_i),
  .rsp_valid_o    (rsp_valid_o),
  .illegal_o      (illegal_o),
  .reset_vstart_o (reset_vstart_o),
  .write_vstart_o (write_vstart_o),
  .set_vstart_o   (set_vstart_o),
  .clear_vstart_o (clear_vstart_o)
);

// File: dv/vdec_tb.sv
// Decoder testbench with clock, reset, random stimulus, reference model and checks
`timescale 1ns/100ps
`include "vdec_cfg.svh"

module vdec_tb;
  import vdec_pkg::*;

  localparam int NUM_CYCLES  = 3000;
  localparam int RST_TIMEOUT = 20;

  localparam logic [5:0] F6_TAB [0:8] = '{F6_VADD, F6_VSUB, F6_VRSUB, F6_VAND, F6_VOR,
                                          F6_VXOR, F6_VSLL, F6_VSRL, F6_VSRA};
  localparam logic [11:0] CSR_TAB [0:6] = '{CSR_VSTART, CSR_VXSAT, CSR_VXRM, CSR_VCSR,
                                            CSR_VL, CSR_VTYPE, CSR_VLENB};
  localparam logic [2:0] CSR_F3_TAB [0:5] = '{3'b001, 3'b010, 3'b011, 3'b101, 3'b110, 3'b111};

  logic                     clk_i;
  logic                     rst_n_i;
  logic                     req_valid_i;
  logic [31:0]              instr_i;
  logic [`VDEC_XLEN-1:0]    rs1_i;
  logic                     rs1_valid_i;
  logic [`VDEC_XLEN-1:0]    rs2_i;
  logic                     rs2_valid_i;
  logic [`VDEC_ID_W-1:0]    id_i;
  logic                     rsp_valid_o;
  logic                     illegal_o;
  logic [`VDEC_ID_W-1:0]    id_o;
  logic [4:0]               op_o;
  logic [1:0]               ex_unit_o;
  logic [`VDEC_VREG_W-1:0]  vd_o;
  logic [`VDEC_VREG_W-1:0]  vs1_o;
  logic [`VDEC_VREG_W-1:0]  vs2_o;
  logic [`VDEC_VREG_W-1:0]  rd_o;
  logic                     use_vd_o;
  logic                     use_vs1_o;
  logic                     use_vs2_o;
  logic                     use_rd_o;
  logic                     vd_is_src_o;
  logic [`VDEC_XLEN-1:0]    rs1_o;
  logic [`VDEC_XLEN-1:0]    rs2_o;
  logic [1:0]               vsew_o;
  logic                     vm_o;
  logic                     is_load_o;
  logic [`VDEC_VTYPE_W-1:0] vtype_o;
  logic                     keep_vl_o;
  logic [`VDEC_CSR_W-1:0]   csr_addr_o;
  logic                     write_vstart_o;
  logic                     set_vstart_o;
  logic                     clear_vstart_o;
  logic                     reset_vstart_o;

  integer    seed;
  integer    errors;
  integer    checks;
  integer    n_req;
  integer    n_illegal;
  integer    wait_cnt;
  logic      checking;

  // Request driven on the last edge, and the one the DUT holds now
  logic      nxt_valid;
  logic      nxt_illegal;
  logic      nxt_rst;
  trans_id_t nxt_id;
  vec_req_t  nxt_req;
  logic      exp_valid;
  logic      exp_illegal;
  logic      exp_rst;
  trans_id_t exp_id;
  vec_req_t  exp_req;

  vdec_top dut_i (.*);

  always #10 clk_i = ~clk_i;

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    begin
      checks++;
      if (got !== exp) begin
        errors++;
        $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
      end
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic logic predict_response(input logic [31:0] ins, input xlen_t a,
                                            input logic av, input xlen_t b, input logic bv,
                                            output vec_req_t e);
    logic       bad;
    logic [2:0] f3;
    logic [2:0] forms;
    logic [4:0] s1;
    logic [4:0] d;
    logic       vst;
    begin
      e     = '0;
      bad   = 1'b0;
      f3    = ins[14:12];
      s1    = ins[19:15];
      d     = ins[11:7];
      forms = 3'b000;
      case (ins[6:0])
        7'b0000111, 7'b0100111: begin
          e.ex_unit   = LSU;
          e.vd        = d;
          e.use_vd    = 1'b1;
          e.vm        = ins[25];
          e.rs1       = a;
          e.is_load   = (ins[6:0] == 7'b0000111);
          e.vd_is_src = !e.is_load;
          if ({ins[28], f3} == 4'b0000) e.vsew = EW_8;
          else if ({ins[28], f3} == 4'b0101) e.vsew = EW_16;
          else if ({ins[28], f3} == 4'b0110) e.vsew = EW_32;
          else bad = 1'b1;
          if (ins[31:29] != 3'b000 || !av) bad = 1'b1;
          if (ins[27:26] == 2'b00) begin
            e.op = e.is_load ? VLE : VSE;
            if (ins[24:20] != 5'b0) bad = 1'b1;
          end else if (ins[27:26] == 2'b10) begin
            e.op  = e.is_load ? VLSE : VSSE;
            e.rs2 = b;
            if (!bv) bad = 1'b1;
          end else begin
            bad = 1'b1;
          end
        end
        7'b1010111: begin
          if (f3 == 3'b111) begin
            e.op      = VCFG;
            e.ex_unit = CON;
            e.rd      = d;
            e.use_rd  = 1'b1;
            if (!ins[31]) begin
              e.vtype = {1'b0, ins[27:20]};
              e.rs1   = a;
              bad     = !av;
            end else if (ins[30]) begin
              e.vtype = {1'b0, ins[27:20]};
              e.rs1   = {27'b0, s1};
            end else if (ins[30:25] == 6'b000000) begin
              e.vtype = {1'b0, b[7:0]};
              e.rs1   = a;
              bad     = !av || !bv;
            end else begin
              bad = 1'b1;
            end
            if (s1 == 5'b0 && d != 5'b0) e.rs1 = 32'hffff_ffff;
            e.keep_vl = (s1 == 5'b0) && (d == 5'b0);
          end else begin
            e.ex_unit = VFU;
            e.vs2     = ins[24:20];
            e.use_vs2 = 1'b1;
            e.vd      = d;
            e.use_vd  = 1'b1;
            e.vm      = ins[25];
            // Legal forms as VV, VX, VI
            case (ins[31:26])
              6'b000000: begin
                e.op  = VADD;
                forms = 3'b111;
              end
              6'b000010: begin
                e.op  = VSUB;
                forms = 3'b110;
              end
              6'b000011: begin
                e.op  = VRSUB;
                forms = 3'b011;
              end
              6'b001001: begin
                e.op  = VAND;
                forms = 3'b111;
              end
              6'b001010: begin
                e.op  = VOR;
                forms = 3'b111;
              end
              6'b001011: begin
                e.op  = VXOR;
                forms = 3'b111;
              end
              6'b100101: begin
                e.op  = VSLL;
                forms = 3'b111;
              end
              6'b101000: begin
                e.op  = VSRL;
                forms = 3'b111;
              end
              6'b101001: begin
                e.op  = VSRA;
                forms = 3'b111;
              end
              default:   forms = 3'b000;
            endcase
            if (f3 == 3'b000) begin
              e.vs1     = s1;
              e.use_vs1 = 1'b1;
              bad       = !forms[2];
            end else if (f3 == 3'b100) begin
              e.rs1 = a;
              bad   = !av || !forms[1];
            end else if (f3 == 3'b011) begin
              e.rs1 = {{27{s1[4]}}, s1};
              bad   = !forms[0];
            end else begin
              bad = 1'b1;
            end
          end
        end
        7'b1110011: begin
          e.op       = VCSR;
          e.ex_unit  = CON;
          e.rd       = d;
          e.use_rd   = 1'b1;
          e.csr_addr = ins[31:20];
          case (ins[31:20])
            12'h008, 12'h009, 12'h00A, 12'h00F, 12'hC20, 12'hC21, 12'hC22: bad = 1'b0;
            default: bad = 1'b1;
          endcase
          if (f3[2]) begin
            e.rs1 = {27'b0, s1};
          end else begin
            e.rs1 = a;
            if (!av) bad = 1'b1;
          end
          vst = (ins[31:20] == 12'h008);
          if (f3[1:0] == 2'b01) begin
            e.write_vstart = vst;
            if (vst) e.use_rd = (d != 5'b0);
          end else if (f3[1:0] == 2'b10) begin
            e.set_vstart = vst && (s1 != 5'b0);
          end else if (f3[1:0] == 2'b11) begin
            e.clear_vstart = vst && (s1 != 5'b0);
          end else begin
            bad = 1'b1;
          end
        end
        default: bad = 1'b1;
      endcase
      return bad;
    end
  endfunction

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic build_instr(output logic [31:0] ins);
    logic [31:0] r;
    logic [31:0] m;
    int          cls;
    begin
      r   = $random(seed);
      m   = $random(seed);
      cls = {$random(seed)} % 5;
      ins = r;
      case (cls)
        0: begin
          ins[6:0]   = m[0] ? OPC_STORE_FP : OPC_LOAD_FP;
          ins[31:29] = 3'b000;
          case (m[2:1])
            2'b00:   {ins[28], ins[14:12]} = 4'b0000;
            2'b01:   {ins[28], ins[14:12]} = 4'b0101;
            default: {ins[28], ins[14:12]} = 4'b0110;
          endcase
          ins[27:26] = m[3] ? 2'b10 : 2'b00;
          if (!m[3]) ins[24:20] = 5'b0;
        end
        1: begin
          ins[6:0]   = OPC_VEC;
          ins[14:12] = OPCFG;
          case (m[1:0])
            2'b00:   ins[31]    = 1'b0;
            2'b01:   ins[31:30] = 2'b11;
            default: ins[31:25] = 7'b1000000;
          endcase
          // Zero fields hit the max-vl and keep-vl rules
          if (m[3:2] == 2'b00) ins[19:15] = 5'b0;
          if (m[5:4] == 2'b00) ins[11:7] = 5'b0;
        end
        2: begin
          ins[6:0]   = OPC_VEC;
          ins[31:26] = F6_TAB[{m[15:8]} % 9];
          case (m[1:0])
            2'b00:   ins[14:12] = OPIVV;
            2'b01:   ins[14:12] = OPIVI;
            default: ins[14:12] = OPIVX;
          endcase
        end
        3: begin
          ins[6:0]   = OPC_SYSTEM;
          ins[31:20] = CSR_TAB[{m[15:8]} % 7];
          ins[14:12] = CSR_F3_TAB[{m[23:16]} % 6];
          if (m[1:0] == 2'b00) ins[19:15] = 5'b0;
        end
        default: ins = r;
      endcase
      if ({$random(seed)} % 100 < 15) ins[31:7] = m[31:7] ^ r[24:0];
    end
  endtask

  task automatic run_stimulus();
    logic [31:0] ins;
    logic [31:0] r;
    xlen_t       a;
    xlen_t       b;
    logic        av;
    logic        bv;
    logic        vld;
    integer      cyc;
    begin
      for (cyc = 0; cyc < NUM_CYCLES + 2; cyc++) begin
        @(posedge clk_i);
        exp_valid   = nxt_valid;
        exp_illegal = nxt_illegal;
        exp_rst     = nxt_rst;
        exp_id      = nxt_id;
        exp_req     = nxt_req;
        build_instr(ins);
        r   = $random(seed);
        a   = $random(seed);
        b   = $random(seed);
        av  = (r[3:0] != 4'h0);
        bv  = (r[7:4] != 4'h0);
        vld = (cyc < NUM_CYCLES) && ({$random(seed)} % 100 < 80);
        nxt_valid   = vld;
        nxt_id      = r[11:8];
        nxt_illegal = predict_response(ins, a, av, b, bv, nxt_req);
        nxt_rst     = vld && !nxt_illegal && (ins[6:0] != OPC_SYSTEM);
        if (vld) begin
          n_req++;
          if (nxt_illegal) n_illegal++;
        end
        req_valid_i <= vld;
        instr_i     <= ins;
        rs1_i       <= a;
        rs1_valid_i <= av;
        rs2_i       <= b;
        rs2_valid_i <= bv;
        id_i        <= r[11:8];
      end
    end
  endtask

  task automatic compare_request();
    begin
      check_field("op_o", op_o, exp_req.op);
      check_field("ex_unit_o", ex_unit_o, exp_req.ex_unit);
      check_field("vd_o", vd_o, exp_req.vd);
      check_field("vs1_o", vs1_o, exp_req.vs1);
      check_field("vs2_o", vs2_o, exp_req.vs2);
      check_field("rd_o", rd_o, exp_req.rd);
      check_field("use_vd_o", use_vd_o, exp_req.use_vd);
      check_field("use_vs1_o", use_vs1_o, exp_req.use_vs1);
      check_field("use_vs2_o", use_vs2_o, exp_req.use_vs2);
      check_field("use_rd_o", use_rd_o, exp_req.use_rd);
      check_field("vd_is_src_o", vd_is_src_o, exp_req.vd_is_src);
      check_field("rs1_o", rs1_o, exp_req.rs1);
      check_field("rs2_o", rs2_o, exp_req.rs2);
      check_field("vsew_o", vsew_o, exp_req.vsew);
      check_field("vm_o", vm_o, exp_req.vm);
      check_field("is_load_o", is_load_o, exp_req.is_load);
      check_field("vtype_o", vtype_o, exp_req.vtype);
      check_field("keep_vl_o", keep_vl_o, exp_req.keep_vl);
      check_field("csr_addr_o", csr_addr_o, exp_req.csr_addr);
      check_field("write_vstart_o", write_vstart_o, exp_req.write_vstart);
      check_field("set_vstart_o", set_vstart_o, exp_req.set_vstart);
      check_field("clear_vstart_o", clear_vstart_o, exp_req.clear_vstart);
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (checking) begin
      check_field("rsp_valid_o", rsp_valid_o, exp_valid);
      if (exp_valid) begin
        check_field("id_o", id_o, exp_id);
        check_field("illegal_o", illegal_o, exp_illegal);
        check_field("reset_vstart_o", reset_vstart_o, exp_rst);
        if (!exp_illegal) compare_request();
      end else begin
        check_field("illegal_o", illegal_o, 1'b0);
        check_field("reset_vstart_o", reset_vstart_o, 1'b0);
      end
    end
  end

  initial begin
    seed        = 32'hbee7;
    errors      = 0;
    checks      = 0;
    n_req       = 0;
    n_illegal   = 0;
    checking    = 1'b0;
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    instr_i     = '0;
    rs1_i       = '0;
    rs1_valid_i = 1'b0;
    rs2_i       = '0;
    rs2_valid_i = 1'b0;
    id_i        = '0;
    nxt_valid   = 1'b0;
    nxt_illegal = 1'b0;
    nxt_rst     = 1'b0;
    nxt_id      = '0;
    nxt_req     = '0;
    // Nothing is pending in the DUT right after reset
    exp_valid   = 1'b0;
    exp_illegal = 1'b0;
    exp_rst     = 1'b0;
    exp_id      = '0;
    exp_req     = '0;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    wait_cnt = 0;
    while (rst_n_i !== 1'b1 && wait_cnt < RST_TIMEOUT) begin
      @(posedge clk_i);
      wait_cnt++;
    end
    if (rst_n_i !== 1'b1) begin
      $display("Reset release not seen within %0d cycles", RST_TIMEOUT);
      $display("Test failed");
    end else begin
      checking = 1'b1;
      run_stimulus();
      $display("Checks %0d, errors %0d, requests %0d, illegal %0d",
               checks, errors, n_req, n_illegal);
      if (errors == 0) begin
        $display("Test passed");
      end else begin
        $display("Test failed");
      end
    end
    $finish;
  end

endmodule

// File: include/vdec_cfg.svh
// Width macros for the vector decoder: operand, id, register index, vtype, CSR address
`ifndef VDEC_CFG_SVH
`define VDEC_CFG_SVH

// Scalar operand width
`define VDEC_XLEN 32

// Transaction id width
`define VDEC_ID_W 4

// Vector and scalar register index width
`define VDEC_VREG_W 5

// vtype field width
`define VDEC_VTYPE_W 9

// CSR address width
`define VDEC_CSR_W 12

`endif

// File: run.sh
#!/bin/sh
# Compile and run the vector decoder testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal -f build.f --top-module vdec_tb -o vdec_sim \
  && ./obj_dir/vdec_sim > sim.log 2>&1 \
  || echo "Build or simulation run stopped with an error"
cat sim.log 2>/dev/null
grep -q "^Test passed$" sim.log && exit 0 || exit 1
